// ==== verilog/merge_pkg.sv ====
package merge_pkg;

   // Record layout, key in the low bits
   localparam int KEY_W = 16;
   localparam int REC_W = 32;

   typedef logic [KEY_W-1:0] key_t;
   typedef logic [REC_W-KEY_W-1:0] payload_t;

   typedef struct packed {
      payload_t payload;
      key_t     key;
   } rec_t;

   // Four records per word, r0 holds the smallest key
   typedef struct packed {
      rec_t r3;
      rec_t r2;
      rec_t r1;
      rec_t r0;
   } word_t;

   // Per-run sequence of the merge control
   typedef enum logic [2:0] {
      ST_IDLE  = 3'd0,
      ST_PRIME = 3'd1,
      ST_MERGE = 3'd2,
      ST_FLUSH = 3'd3,
      ST_TERM  = 3'd4,
      ST_DRAIN = 3'd5
   } ctrl_state_t;

endpackage

// ==== verilog/word_fifo.sv ====
`timescale 1ns/100ps

module word_fifo #(
   parameter int DEPTH = 16
) (
   input  logic                i_clk,
   input  logic                i_rst,
   input  logic                i_push,
   input  merge_pkg::word_t    i_data,
   input  logic                i_pop,
   output merge_pkg::word_t    o_head,
   output logic                o_empty,
   output logic                o_full,
   output logic                o_almost_full
);

   localparam int AW = $clog2(DEPTH);

   localparam logic [AW-1:0] PTR_LAST  = AW'(DEPTH - 1);
   localparam logic [AW:0]   CNT_FULL  = (AW + 1)'(DEPTH);
   // Two free entries left counts as almost full
   localparam logic [AW:0]   CNT_AFULL = (AW + 1)'(DEPTH - 2);

   merge_pkg::word_t mem [DEPTH];

   logic [AW-1:0] wr_ptr_q;
   logic [AW-1:0] rd_ptr_q;
   logic [AW:0]   count_q;

   always_ff @(posedge i_clk) begin
      if (i_push) begin
         mem[wr_ptr_q] <= i_data;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
      end else begin
         if (i_push) begin
            wr_ptr_q <= (wr_ptr_q == PTR_LAST) ? '0 : wr_ptr_q + 1'b1;
         end
         if (i_pop) begin
            rd_ptr_q <= (rd_ptr_q == PTR_LAST) ? '0 : rd_ptr_q + 1'b1;
         end
      end
   end

   // Simultaneous push and pop leaves the count alone
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         count_q <= '0;
      end else begin
         case ({i_push, i_pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   // Show-ahead, oldest word always visible
   assign o_head        = mem[rd_ptr_q];
   assign o_empty       = (count_q == '0);
   assign o_full        = (count_q == CNT_FULL);
   assign o_almost_full = (count_q >= CNT_AFULL);

endmodule

// ==== verilog/merge_ctrl.sv ====
`timescale 1ns/100ps

module merge_ctrl (
   input  logic                     i_clk,
   input  logic                     i_rst,
   input  merge_pkg::word_t         i_head_a,
   input  merge_pkg::word_t         i_head_b,
   input  logic                     i_empty_a,
   input  logic                     i_empty_b,
   input  logic                     i_out_almost_full,
   output logic                     o_pop_a,
   output logic                     o_pop_b,
   output logic                     o_load,
   output logic                     o_sel_b,
   output logic                     o_emit,
   output logic                     o_flush,
   output logic                     o_term,
   output merge_pkg::ctrl_state_t   o_state
);

   merge_pkg::ctrl_state_t state_q;
   merge_pkg::ctrl_state_t state_d;

   logic term_a;
   logic term_b;
   logic both_term;
   logic heads_ok;
   logic b_lt_a;
   logic pick_b;
   logic take;

   // All-zero head word ends its stream
   assign term_a    = (i_head_a == '0);
   assign term_b    = (i_head_b == '0);
   assign both_term = term_a & term_b;

   // Both heads must be visible before any decision
   assign heads_ok = ~i_empty_a & ~i_empty_b;

   // Ties go to stream a
   assign b_lt_a = (i_head_b.r0.key < i_head_a.r0.key);
   assign pick_b = term_a | (~term_b & b_lt_a);

   always_comb begin
      state_d = state_q;
      take    = 1'b0;
      o_emit  = 1'b0;
      o_flush = 1'b0;
      o_term  = 1'b0;
      o_pop_a = 1'b0;
      o_pop_b = 1'b0;

      case (state_q)
         merge_pkg::ST_IDLE: begin
            if (heads_ok) begin
               state_d = merge_pkg::ST_PRIME;
            end
         end

         // First word fills the kept register, nothing is emitted
         merge_pkg::ST_PRIME: begin
            if (heads_ok) begin
               if (both_term) begin
                  state_d = merge_pkg::ST_TERM;
               end else begin
                  take    = 1'b1;
                  state_d = merge_pkg::ST_MERGE;
               end
            end
         end

         merge_pkg::ST_MERGE: begin
            if (heads_ok && both_term) begin
               state_d = merge_pkg::ST_FLUSH;
            end else if (heads_ok && !i_out_almost_full) begin
               take   = 1'b1;
               o_emit = 1'b1;
            end
         end

         merge_pkg::ST_FLUSH: begin
            if (!i_out_almost_full) begin
               o_flush = 1'b1;
               o_emit  = 1'b1;
               state_d = merge_pkg::ST_TERM;
            end
         end

         merge_pkg::ST_TERM: begin
            if (!i_out_almost_full) begin
               o_term  = 1'b1;
               o_emit  = 1'b1;
               state_d = merge_pkg::ST_DRAIN;
            end
         end

         // Drop both terminators before the next pair of streams
         merge_pkg::ST_DRAIN: begin
            o_pop_a = ~i_empty_a;
            o_pop_b = ~i_empty_b;
            state_d = merge_pkg::ST_IDLE;
         end

         default: begin
            state_d = merge_pkg::ST_IDLE;
         end
      endcase

      if (take) begin
         o_pop_a = ~pick_b;
         o_pop_b = pick_b;
      end
   end

   assign o_load  = take;
   assign o_sel_b = pick_b;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         state_q <= merge_pkg::ST_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   assign o_state = state_q;

endmodule

// ==== verilog/bitonic_merge_8.sv ====
`timescale 1ns/100ps

module bitonic_merge_8 (
   input  logic               i_clk,
   input  logic               i_rst,
   input  logic               i_load,
   input  logic               i_emit,
   input  logic               i_flush,
   input  logic               i_term,
   input  merge_pkg::word_t   i_word,
   output merge_pkg::word_t   o_word,
   output logic               o_write
);

   merge_pkg::word_t kept_q;
   merge_pkg::word_t out_q;
   logic             write_q;

   merge_pkg::rec_t stg0 [8];
   merge_pkg::rec_t stg1 [8];
   merge_pkg::rec_t stg2 [8];
   merge_pkg::rec_t stg3 [8];

   merge_pkg::word_t lo_word;
   merge_pkg::word_t hi_word;

   function automatic merge_pkg::rec_t pick_lo(merge_pkg::rec_t x, merge_pkg::rec_t y);
      return (x.key <= y.key) ? x : y;
   endfunction

   function automatic merge_pkg::rec_t pick_hi(merge_pkg::rec_t x, merge_pkg::rec_t y);
      return (x.key <= y.key) ? y : x;
   endfunction

   // New word ascending, kept word reversed, gives a bitonic sequence
   always_comb begin
      stg0[0] = i_word.r0;
      stg0[1] = i_word.r1;
      stg0[2] = i_word.r2;
      stg0[3] = i_word.r3;
      stg0[4] = kept_q.r3;
      stg0[5] = kept_q.r2;
      stg0[6] = kept_q.r1;
      stg0[7] = kept_q.r0;
   end

   // Distance 4, splits smallest four from largest four
   always_comb begin
      for (int i = 0; i < 4; i++) begin
         stg1[i]     = pick_lo(stg0[i], stg0[i + 4]);
         stg1[i + 4] = pick_hi(stg0[i], stg0[i + 4]);
      end
   end

   // Distance 2 inside each half
   always_comb begin
      for (int g = 0; g < 8; g += 4) begin
         for (int i = 0; i < 2; i++) begin
            stg2[g + i]     = pick_lo(stg1[g + i], stg1[g + i + 2]);
            stg2[g + i + 2] = pick_hi(stg1[g + i], stg1[g + i + 2]);
         end
      end
   end

   // Distance 1, neighbours
   always_comb begin
      for (int i = 0; i < 8; i += 2) begin
         stg3[i]     = pick_lo(stg2[i], stg2[i + 1]);
         stg3[i + 1] = pick_hi(stg2[i], stg2[i + 1]);
      end
   end

   always_comb begin
      lo_word.r0 = stg3[0];
      lo_word.r1 = stg3[1];
      lo_word.r2 = stg3[2];
      lo_word.r3 = stg3[3];
      hi_word.r0 = stg3[4];
      hi_word.r1 = stg3[5];
      hi_word.r2 = stg3[6];
      hi_word.r3 = stg3[7];
   end

   // Kept word returns to zero after a flush, ready to prime the next run
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         kept_q  <= '0;
         write_q <= 1'b0;
      end else begin
         write_q <= i_emit;
         if (i_flush) begin
            kept_q <= '0;
         end else if (i_load) begin
            kept_q <= hi_word;
         end
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_emit) begin
         if (i_term) begin
            out_q <= '0;
         end else if (i_flush) begin
            out_q <= kept_q;
         end else begin
            out_q <= lo_word;
         end
      end
   end

   assign o_word  = out_q;
   assign o_write = write_q;

endmodule

// ==== verilog/merge_4.sv ====
`timescale 1ns/100ps

module merge_4 #(
   parameter int IN_DEPTH  = 16,
   parameter int OUT_DEPTH = 32
) (
   input  logic                     i_clk,
   input  logic                     i_rst,
   input  merge_pkg::word_t         i_a_data,
   input  logic                     i_a_empty,
   output logic                     o_a_read,
   input  merge_pkg::word_t         i_b_data,
   input  logic                     i_b_empty,
   output logic                     o_b_read,
   input  logic                     i_out_ready,
   output logic                     o_out_write,
   output merge_pkg::word_t         o_out_data,
   output merge_pkg::ctrl_state_t   o_state
);

   merge_pkg::word_t head_a;
   merge_pkg::word_t head_b;
   merge_pkg::word_t sel_word;
   merge_pkg::word_t net_word;

   logic a_empty;
   logic a_full;
   logic b_empty;
   logic b_full;
   logic out_empty;
   logic out_afull;

   logic pop_a;
   logic pop_b;
   logic load;
   logic sel_b;
   logic emit;
   logic flush;
   logic term;
   logic net_write;
   logic ready_q;

   // Pull from the external FIFOs while there is room
   assign o_a_read = ~i_a_empty & ~a_full;
   assign o_b_read = ~i_b_empty & ~b_full;

   word_fifo #(.DEPTH(IN_DEPTH)) a_fifo_i (
      .i_clk         (i_clk),
      .i_rst         (i_rst),
      .i_push        (o_a_read),
      .i_data        (i_a_data),
      .i_pop         (pop_a),
      .o_head        (head_a),
      .o_empty       (a_empty),
      .o_full        (a_full),
      .o_almost_full ()
   );

   word_fifo #(.DEPTH(IN_DEPTH)) b_fifo_i (
      .i_clk         (i_clk),
      .i_rst         (i_rst),
      .i_push        (o_b_read),
      .i_data        (i_b_data),
      .i_pop         (pop_b),
      .o_head        (head_b),
      .o_empty       (b_empty),
      .o_full        (b_full),
      .o_almost_full ()
   );

   merge_ctrl merge_ctrl_i (
      .i_clk             (i_clk),
      .i_rst             (i_rst),
      .i_head_a          (head_a),
      .i_head_b          (head_b),
      .i_empty_a         (a_empty),
      .i_empty_b         (b_empty),
      .i_out_almost_full (out_afull),
      .o_pop_a           (pop_a),
      .o_pop_b           (pop_b),
      .o_load            (load),
      .o_sel_b           (sel_b),
      .o_emit            (emit),
      .o_flush           (flush),
      .o_term            (term),
      .o_state           (o_state)
   );

   assign sel_word = sel_b ? head_b : head_a;

   bitonic_merge_8 bitonic_merge_8_i (
      .i_clk   (i_clk),
      .i_rst   (i_rst),
      .i_load  (load),
      .i_emit  (emit),
      .i_flush (flush),
      .i_term  (term),
      .i_word  (sel_word),
      .o_word  (net_word),
      .o_write (net_write)
   );

   // Sink ready is seen one cycle late
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         ready_q <= 1'b0;
      end else begin
         ready_q <= i_out_ready;
      end
   end

   assign o_out_write = ready_q & ~out_empty;

   word_fifo #(.DEPTH(OUT_DEPTH)) out_fifo_i (
      .i_clk         (i_clk),
      .i_rst         (i_rst),
      .i_push        (net_write),
      .i_data        (net_word),
      .i_pop         (o_out_write),
      .o_head        (o_out_data),
      .o_empty       (out_empty),
      .o_full        (),
      .o_almost_full (out_afull)
   );

endmodule

// ==== dv/merge_4_tb.sv ====
`timescale 1ns/100ps

module merge_4_tb;

   localparam int READY_HIGH   = 0;
   localparam int READY_RANDOM = 1;
   localparam int READY_LOW    = 2;

   logic                   i_clk;
   logic                   i_rst;
   merge_pkg::word_t       i_a_data;
   logic                   i_a_empty;
   logic                   o_a_read;
   merge_pkg::word_t       i_b_data;
   logic                   i_b_empty;
   logic                   o_b_read;
   logic                   i_out_ready;
   logic                   o_out_write;
   merge_pkg::word_t       o_out_data;
   merge_pkg::ctrl_state_t o_state;

   // External FIFO contents with the head at index 0
   merge_pkg::word_t qa[$];
   merge_pkg::word_t qb[$];
   merge_pkg::word_t pend_a[$];
   merge_pkg::word_t pend_b[$];
   merge_pkg::word_t exp_q[$];
   merge_pkg::word_t got_q[$];

   int terms_seen = 0;
   int idle_returns = 0;
   int ready_mode = READY_HIGH;
   merge_pkg::ctrl_state_t last_state = merge_pkg::ST_IDLE;

   merge_4 #(.IN_DEPTH(16), .OUT_DEPTH(32)) merge_4_i (.*);

   initial begin
      i_clk = 1'b0;
      forever #5 i_clk = ~i_clk;
   end

   task automatic abort_run();
      $display("RESULT: FAIL");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task automatic check_word(string name, merge_pkg::word_t exp, merge_pkg::word_t act);
      if (act !== exp) begin
         $display("Fail %s: expected 0x%h, got 0x%h", name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_state(string name, merge_pkg::ctrl_state_t exp,
                              merge_pkg::ctrl_state_t act);
      if (act !== exp) begin
         $display("Fail %s: expected 0x%h, got 0x%h", name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_bit(string name, logic exp, logic act);
      if (act !== exp) begin
         $display("Fail %s: expected 0x%h, got 0x%h", name, exp, act);
         abort_run();
      end
   endtask

   // Show-ahead model of the two external FIFOs
   always @(posedge i_clk) begin
      if (o_a_read) begin
         void'(qa.pop_front());
      end
      if (o_b_read) begin
         void'(qb.pop_front());
      end
      i_a_empty <= (qa.size() == 0);
      i_b_empty <= (qb.size() == 0);
      if (qa.size() != 0) begin
         i_a_data <= qa[0];
      end
      if (qb.size() != 0) begin
         i_b_data <= qb[0];
      end
   end

   always @(posedge i_clk) begin
      case (ready_mode)
         READY_RANDOM: i_out_ready <= ($urandom() & 32'd1) != 32'd0;
         READY_LOW:    i_out_ready <= 1'b0;
         default:      i_out_ready <= 1'b1;
      endcase
   end

   // Sink takes one word per write strobe
   always @(posedge i_clk) begin
      if (!i_rst && o_out_write) begin
         got_q.push_back(o_out_data);
         if (o_out_data == '0) begin
            terms_seen++;
         end
      end
   end

   // Count each return to IDLE
   always @(posedge i_clk) begin
      if (!i_rst && o_state == merge_pkg::ST_IDLE && last_state != merge_pkg::ST_IDLE) begin
         idle_returns++;
      end
      last_state <= o_state;
   end

   function automatic merge_pkg::word_t group_word(merge_pkg::rec_t recs[$], int base);
      merge_pkg::word_t w;
      w.r0 = recs[base];
      w.r1 = recs[base + 1];
      w.r2 = recs[base + 2];
      w.r3 = recs[base + 3];
      return w;
   endfunction

   // Keys rise monotonically, so all_recs is the sorted merge of both streams
   task automatic build_run(int na, int nb);
      merge_pkg::rec_t recs_a[$];
      merge_pkg::rec_t recs_b[$];
      merge_pkg::rec_t all_recs[$];
      merge_pkg::rec_t r;
      merge_pkg::key_t key;
      int left_a;
      int left_b;
      key = '0;
      left_a = na * 4;
      left_b = nb * 4;
      while (left_a + left_b > 0) begin
         key = key + merge_pkg::key_t'(32'd1 + $urandom() % 8);
         r.key = key;
         r.payload = merge_pkg::payload_t'($urandom());
         all_recs.push_back(r);
         if (left_b == 0 || (left_a > 0 && $urandom() % 2 == 0)) begin
            recs_a.push_back(r);
            left_a--;
         end else begin
            recs_b.push_back(r);
            left_b--;
         end
      end
      for (int i = 0; i < recs_a.size(); i += 4) begin
         pend_a.push_back(group_word(recs_a, i));
      end
      for (int i = 0; i < recs_b.size(); i += 4) begin
         pend_b.push_back(group_word(recs_b, i));
      end
      for (int i = 0; i < all_recs.size(); i += 4) begin
         exp_q.push_back(group_word(all_recs, i));
      end
      pend_a.push_back('0);
      pend_b.push_back('0);
      exp_q.push_back('0);
   endtask

   task automatic load_streams(bit with_b);
      while (pend_a.size() != 0) begin
         qa.push_back(pend_a.pop_front());
      end
      while (with_b && pend_b.size() != 0) begin
         qb.push_back(pend_b.pop_front());
      end
   endtask

   task automatic wait_terms(int target, int limit);
      int cycles;
      cycles = 0;
      while (terms_seen < target) begin
         @(negedge i_clk);
         cycles++;
         if (cycles > limit) begin
            $display("Timed out after %0d cycles waiting for terminator %0d", limit, target);
            abort_run();
         end
      end
   endtask

   task automatic compare_output();
      @(negedge i_clk);
      if (got_q.size() != exp_q.size()) begin
         $display("Received %0d output words where %0d were expected",
                  got_q.size(), exp_q.size());
         abort_run();
      end
      for (int i = 0; i < exp_q.size(); i++) begin
         check_word($sformatf("o_out_data[%0d]", i), exp_q[i], got_q[i]);
      end
      check_state("o_state", merge_pkg::ST_IDLE, o_state);
      got_q.delete();
      exp_q.delete();
      terms_seen = 0;
   endtask

   task automatic after_reset();
      for (int i = 0; i < 11; i++) begin
         @(posedge i_clk);
         if (i == 9) begin
            i_rst <= 1'b0;
         end
         @(negedge i_clk);
         check_bit("o_a_read", 1'b0, o_a_read);
         check_bit("o_b_read", 1'b0, o_b_read);
         check_bit("o_out_write", 1'b0, o_out_write);
         check_state("o_state", merge_pkg::ST_IDLE, o_state);
      end
   endtask

   task automatic interleaved_streams();
      build_run(8, 8);
      load_streams(1'b1);
      wait_terms(1, 500);
      compare_output();
   endtask

   task automatic uneven_streams();
      build_run(12, 0);
      load_streams(1'b1);
      wait_terms(1, 500);
      compare_output();
      // Two bare terminators
      build_run(0, 0);
      load_streams(1'b1);
      wait_terms(1, 100);
      compare_output();
   endtask

   task automatic output_backpressure();
      ready_mode = READY_LOW;
      build_run(40, 40);
      load_streams(1'b1);
      for (int i = 0; i < 60; i++) begin
         @(negedge i_clk);
         if (i >= 54) begin
            check_bit("o_a_read", 1'b0, o_a_read);
            check_bit("o_b_read", 1'b0, o_b_read);
            check_bit("o_out_write", 1'b0, o_out_write);
         end
      end
      ready_mode = READY_RANDOM;
      wait_terms(1, 3000);
      compare_output();
      ready_mode = READY_HIGH;
   endtask

   // Stream b trickles in with gaps of 3 to 8 cycles
   task automatic starved_input();
      int cycles;
      int next_feed;
      build_run(10, 10);
      load_streams(1'b0);
      cycles = 0;
      next_feed = 0;
      while (terms_seen < 1) begin
         @(negedge i_clk);
         cycles++;
         if (cycles >= next_feed && pend_b.size() != 0) begin
            qb.push_back(pend_b.pop_front());
            next_feed = cycles + 3 + int'($urandom() % 6);
         end
         if (cycles > 2000) begin
            $display("Timed out waiting for the terminator of the starved run");
            abort_run();
         end
      end
      compare_output();
   endtask

   task automatic back_to_back_runs();
      int idle_before;
      idle_before = idle_returns;
      for (int run = 0; run < 3; run++) begin
         build_run(4 + run * 3, 6 - run);
      end
      load_streams(1'b1);
      wait_terms(3, 2000);
      compare_output();
      if (idle_returns - idle_before != 3) begin
         $display("State returned to IDLE %0d times over three runs",
                  idle_returns - idle_before);
         abort_run();
      end
   endtask

   initial begin
      i_rst = 1'b1;
      i_a_data = '0;
      i_a_empty = 1'b1;
      i_b_data = '0;
      i_b_empty = 1'b1;
      i_out_ready = 1'b0;
      void'($urandom(4));
      after_reset();
      interleaved_streams();
      uneven_streams();
      output_backpressure();
      starved_input();
      back_to_back_runs();
      $display("RESULT: PASS");
      $finish;
   end

endmodule

// ==== build.f ====
verilog/merge_pkg.sv
verilog/word_fifo.sv
verilog/merge_ctrl.sv
verilog/bitonic_merge_8.sv
verilog/merge_4.sv
dv/merge_4_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the merge_4 testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 -f build.f --top-module merge_4_tb -o merge_4_tb \
   && ./obj_dir/merge_4_tb \
   || { echo "merge_4 simulation failed"; exit 1; }
